//--- all.f
+incdir+.
rotaryPkg.sv
rotaryFilter.sv
rotaryInterface.sv
rotary.sv
rotaryTop.sv
rotaryTb_sva.sv
rotaryTb.sv

//--- Makefile
TOP = rotaryTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)

# the run passes only if the pass line shows up in the output
run: build
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- rotaryTb.sv
`include "rotary_consts.svh"

module rotaryTb;
   import rotaryPkg::*;

   localparam int clockPeriod = 40;
   localparam int settleWait  = 20;   // well past the raw step to pending latency

   // upper bounds per test in cycles, in the order the tests run
   localparam int testCycles = 10 + 50 + 60 + 90 + 50 + 60;

   logic    clock = 1'b0;
   logic    reset;
   instWord inst;
   logic    instEn;
   quadPair rotary;
   logic    rotaryLeft;
   logic    rotaryRight;
   logic    error;

   logic [1:0] pos;                    // encoder position along the Gray sequence
   integer     seed      = 32'h0ffa_b573;
   int         failSeen  = 0;
   int         passCount = 0;
   int         failTests = 0;

   rotaryTop u_dut (
      .clock       (clock),
      .reset       (reset),
      .inst        (inst),
      .instEn      (instEn),
      .rotary      (rotary),
      .rotaryLeft  (rotaryLeft),
      .rotaryRight (rotaryRight),
      .error       (error)
   );

   always #(clockPeriod / 2) clock = ~clock;

   // line pair at each position, phase A in bit 0
   function automatic quadPair pairAt(input logic [1:0] p);
      case (p)
         2'd0:    return 2'b00;
         2'd1:    return 2'b01;
         2'd2:    return 2'b11;
         default: return 2'b10;
      endcase
   endfunction

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge clock);
   endtask

   task automatic issue(input instCode code);
      inst   <= {code, {(`ROTARY_INST_WIDTH - `ROTARY_CODE_WIDTH){1'b0}}};
      instEn <= 1'b1;
      @(posedge clock);
      instEn <= 1'b0;
      inst   <= '0;
   endtask

   task automatic resetDut;
      reset  <= 1'b1;
      instEn <= 1'b0;
      rotary <= 2'b00;                 // filter restarts at 00 as well
      pos = 2'd0;
      idle(2);
      reset <= 1'b0;
   endtask

   task automatic turnRight;
      pos = pos + 2'd1;
      rotary <= pairAt(pos);
      idle(settleWait);
   endtask

   task automatic turnLeft;
      pos = pos - 2'd1;
      rotary <= pairAt(pos);
      idle(settleWait);
   endtask

   task automatic jumpBoth;
      pos = pos + 2'd2;                // both lines flip at once
      rotary <= pairAt(pos);
      idle(settleWait);
   endtask

   // short glitches toward a neighbour, always back home in the end
   task automatic bounce(input logic towardRight, input int rounds);
      int      glitch;
      quadPair home;
      quadPair away;
      home = pairAt(pos);
      away = towardRight ? pairAt(pos + 2'd1) : pairAt(pos - 2'd1);
      for (int i = 0; i < rounds; i++) begin
         glitch = 1 + int'($unsigned($random(seed)) % (`ROTARY_FILTER_CYCLES - 1));
         rotary <= away;
         idle(glitch);
         rotary <= home;
         idle(`ROTARY_FILTER_CYCLES);
      end
      idle(settleWait);
   endtask

   // assertion actions of the last edge are done by the falling edge
   task automatic reportTest(input string name);
      int found;
      @(negedge clock);
      found = u_dut.svaCheck.failCount - failSeen;
      failSeen = u_dut.svaCheck.failCount;
      if (found == 0) begin
         passCount++;
         $display("test %s done, no assertion failed", name);
      end else begin
         failTests++;
         $display("Error in test %s: expected 0 assertion failures, actual %0d", name, found);
      end
      @(posedge clock);
   endtask

   task automatic afterReset;
      resetDut();
      issue(`ROTARY_OP_RDR);           // lands in the stateReset cycle
      issue(`ROTARY_OP_RDL);
      idle(3);
   endtask

   task automatic readBack;
      turnRight();
      issue(`ROTARY_OP_RDR);
      issue(`ROTARY_OP_RDR);
      turnLeft();
      issue(`ROTARY_OP_RDL);
      issue(`ROTARY_OP_RDL);
      idle(2);
   endtask

   task automatic holdOutputs;
      turnRight();
      issue(`ROTARY_OP_RDR);           // right output now high
      issue(`ROTARY_OP_NOP);
      issue(`ROTARY_OP_NOP);
      idle(5);
      issue(`ROTARY_OP_NOP);
      turnLeft();
      issue(`ROTARY_OP_RDR);
      idle(2);
      issue(`ROTARY_OP_RDL);
      issue(`ROTARY_OP_RDL);
      idle(2);
   endtask

   task automatic bounceIgnored;
      bounce(1'b1, 3);
      issue(`ROTARY_OP_RDR);
      bounce(1'b0, 3);
      issue(`ROTARY_OP_RDL);
      idle(2);
   endtask

   task automatic doubleJump;
      jumpBoth();
      issue(`ROTARY_OP_RDL);
      issue(`ROTARY_OP_RDR);
      turnRight();                     // decoding still works from the new spot
      issue(`ROTARY_OP_RDR);
      idle(2);
   endtask

   task automatic errorSticky;
      issue(4'h7);
      idle(2);
      turnRight();
      issue(`ROTARY_OP_RDR);
      issue(`ROTARY_OP_RDL);
      issue(4'hF);
      idle(3);
      resetDut();
      idle(2);
      turnRight();
      issue(`ROTARY_OP_RDR);
      idle(2);
   endtask

   initial begin
      #(testCycles * 2 * clockPeriod);
      $display("timeout: the tests did not finish within %0d cycles", testCycles * 2);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      inst   <= '0;
      instEn <= 1'b0;
      rotary <= 2'b00;
      reset  <= 1'b1;
      pos = 2'd0;

      afterReset();
      reportTest("afterReset");
      readBack();
      reportTest("readBack");
      holdOutputs();
      reportTest("holdOutputs");
      bounceIgnored();
      reportTest("bounceIgnored");
      doubleJump();
      reportTest("doubleJump");
      errorSticky();
      reportTest("errorSticky");

      $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
               passCount, failTests, u_dut.svaCheck.failCount);
      if (failTests == 0 && u_dut.svaCheck.failCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- rotaryTb_sva.sv
`include "rotary_consts.svh"

module rotaryTb_sva (
   input logic               clock,
   input logic               reset,
   input rotaryPkg::instWord inst,
   input logic               instEn,
   input rotaryPkg::quadPair rotary,
   input logic               rotaryLeft,
   input logic               rotaryRight,
   input logic               error
);
   import rotaryPkg::*;

   // raw value has to sit this long before it counts as a step
   localparam int settleCycles = 2 + `ROTARY_FILTER_CYCLES + 1;

   int failCount = 0;            // read by the testbench top

   quadPair rawLast;
   quadPair modelStable;
   int      holdCount;

   logic modelReady;             // low in the cycle right after reset
   logic modelError;
   logic pendLeft;
   logic pendRight;
   logic outLeft;
   logic outRight;

   instCode code;
   logic    readLeft;
   logic    readRight;
   logic    badCode;
   logic    accept;
   logic    stepFwd;
   logic    stepBack;
   logic    expLeft;
   logic    expRight;

   // 00 -> 01 -> 11 -> 10 -> 00 is a right step
   function automatic logic isForward(input quadPair older, input quadPair newer);
      case ({older, newer})
         4'b0001, 4'b0111, 4'b1110, 4'b1000: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic isBackward(input quadPair older, input quadPair newer);
      case ({older, newer})
         4'b0100, 4'b1101, 4'b1011, 4'b0010: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   assign code = inst[`ROTARY_INST_WIDTH-1 -: `ROTARY_CODE_WIDTH];

   assign readLeft  = instEn && modelReady && !modelError && (code == `ROTARY_OP_RDL);
   assign readRight = instEn && modelReady && !modelError && (code == `ROTARY_OP_RDR);
   assign badCode   = instEn && modelReady && !modelError && (code != `ROTARY_OP_NOP)
                      && (code != `ROTARY_OP_RDL) && (code != `ROTARY_OP_RDR);

   assign accept   = (holdCount == settleCycles) && (rawLast != modelStable);
   assign stepFwd  = accept && isForward(modelStable, rawLast);
   assign stepBack = accept && isBackward(modelStable, rawLast);

   // a read shows the old pending flag in its own cycle
   assign expLeft  = badCode ? 1'b0 : (readLeft ? pendLeft : outLeft);
   assign expRight = badCode ? 1'b0 : (readRight ? pendRight : outRight);

   always_ff @(posedge clock) begin
      if (reset) begin
         rawLast     <= '0;
         holdCount   <= 0;
         modelStable <= '0;
      end else begin
         rawLast <= rotary;
         if (rotary != rawLast) begin
            holdCount <= 0;                       // any bounce restarts
         end else if (holdCount < settleCycles) begin
            holdCount <= holdCount + 1;
         end
         if (accept) begin
            modelStable <= rawLast;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         modelReady <= 1'b0;
         modelError <= 1'b0;
         pendLeft   <= 1'b0;
         pendRight  <= 1'b0;
         outLeft    <= 1'b0;
         outRight   <= 1'b0;
      end else begin
         modelReady <= 1'b1;
         if (badCode) begin
            modelError <= 1'b1;
         end
         if (!modelReady || modelError || badCode) begin
            pendLeft  <= 1'b0;
            pendRight <= 1'b0;
            outLeft   <= 1'b0;
            outRight  <= 1'b0;
         end else begin
            if (readLeft) begin
               outLeft  <= pendLeft;
               pendLeft <= 1'b0;
            end
            if (readRight) begin
               outRight  <= pendRight;
               pendRight <= 1'b0;
            end
            if (stepBack) begin
               pendLeft <= 1'b1;
            end
            if (stepFwd) begin
               pendRight <= 1'b1;
            end
         end
      end
   end

   resetQuiet: assert property (@(posedge clock)
      $past(reset) |-> !rotaryLeft && !rotaryRight && !error)
      else begin
         failCount++;
         $error("outputs not low during reset or in the cycle after it");
      end

   leftMatches: assert property (@(posedge clock) disable iff (reset)
      rotaryLeft == expLeft)
      else begin
         failCount++;
         $error("left output: expected %0b, actual %0b",
                $sampled(expLeft), $sampled(rotaryLeft));
      end

   rightMatches: assert property (@(posedge clock) disable iff (reset)
      rotaryRight == expRight)
      else begin
         failCount++;
         $error("right output: expected %0b, actual %0b",
                $sampled(expRight), $sampled(rotaryRight));
      end

   errorMatches: assert property (@(posedge clock) disable iff (reset)
      error == modelError)
      else begin
         failCount++;
         $error("error flag: expected %0b, actual %0b",
                $sampled(modelError), $sampled(error));
      end

   errorQuiet: assert property (@(posedge clock) disable iff (reset)
      error |-> !rotaryLeft && !rotaryRight)
      else begin
         failCount++;
         $error("an output is high while the device is in its error state");
      end

endmodule

bind rotaryTop rotaryTb_sva svaCheck (
   .clock       (clock),
   .reset       (reset),
   .inst        (inst),
   .instEn      (instEn),
   .rotary      (rotary),
   .rotaryLeft  (rotaryLeft),
   .rotaryRight (rotaryRight),
   .error       (error)
);

//--- rotaryTop.sv
module rotaryTop (
   input  logic              clock,
   input  logic              reset,
   input  rotaryPkg::instWord inst,
   input  logic              instEn,
   input  rotaryPkg::quadPair rotary,
   output logic              rotaryLeft,
   output logic              rotaryRight,
   output logic              error
);

   // raw encoder lines go in unsynchronized, the device handles that
   rotary rotaryDevice (
      .clock       (clock),
      .reset       (reset),
      .inst        (inst),
      .instEn      (instEn),
      .rotary      (rotary),
      .rotaryLeft  (rotaryLeft),
      .rotaryRight (rotaryRight),
      .error       (error)
   );

endmodule

//--- rotary.sv
`include "rotary_consts.svh"

module rotary (
   input  logic              clock,
   input  logic              reset,
   input  rotaryPkg::instWord inst,
   input  logic              instEn,
   input  rotaryPkg::quadPair rotary,
   output logic              rotaryLeft,
   output logic              rotaryRight,
   output logic              error
);
   import rotaryPkg::*;

   rotaryState cState;
   rotaryState nState;

   logic cPendLeft;
   logic cOutLeft;
   logic cPendRight;
   logic cOutRight;

   logic nPendLeft;
   logic nOutLeft;
   logic nPendRight;
   logic nOutRight;

   instCode code;

   logic stepLeft;
   logic stepRight;

   assign code = inst[`ROTARY_INST_WIDTH-1 -: `ROTARY_CODE_WIDTH];

   // next-state values go straight out, a read shows up in its own cycle
   assign rotaryLeft  = nOutLeft;
   assign rotaryRight = nOutRight;
   assign error       = (cState == stateError);

   rotaryInterface stepUnit (
      .clock     (clock),
      .reset     (reset),
      .rotary    (rotary),
      .stepLeft  (stepLeft),
      .stepRight (stepRight)
   );

   always_ff @(posedge clock) begin
      if (reset) begin
         cState     <= stateReset;
         cPendLeft  <= 1'b0;
         cOutLeft   <= 1'b0;
         cPendRight <= 1'b0;
         cOutRight  <= 1'b0;
      end else begin
         cState     <= nState;
         cPendLeft  <= nPendLeft;
         cOutLeft   <= nOutLeft;
         cPendRight <= nPendRight;
         cOutRight  <= nOutRight;
      end
   end

   always_comb begin
      // ready and idle: pending flags collect steps, outputs hold
      nState     = cState;
      nPendLeft  = cPendLeft | stepLeft;
      nOutLeft   = cOutLeft;
      nPendRight = cPendRight | stepRight;
      nOutRight  = cOutRight;

      case (cState)
         stateReset: begin
            nState     = stateReady;
            nPendLeft  = 1'b0;
            nOutLeft   = 1'b0;
            nPendRight = 1'b0;
            nOutRight  = 1'b0;
         end

         stateReady: begin
            if (instEn) begin
               case (code)
                  `ROTARY_OP_NOP: begin
                  end
                  `ROTARY_OP_RDL: begin
                     nPendLeft = stepLeft;      // a step in the read cycle is kept
                     nOutLeft  = cPendLeft;
                  end
                  `ROTARY_OP_RDR: begin
                     nPendRight = stepRight;
                     nOutRight  = cPendRight;
                  end
                  default: begin
                     nState     = stateError;   // sticky until reset
                     nPendLeft  = 1'b0;
                     nOutLeft   = 1'b0;
                     nPendRight = 1'b0;
                     nOutRight  = 1'b0;
                  end
               endcase
            end
         end

         default: begin                         // stateError or a corrupt encoding
            nState     = stateError;
            nPendLeft  = 1'b0;
            nOutLeft   = 1'b0;
            nPendRight = 1'b0;
            nOutRight  = 1'b0;
         end
      endcase
   end

endmodule

//--- rotaryInterface.sv
module rotaryInterface (
   input  logic              clock,
   input  logic              reset,
   input  rotaryPkg::quadPair rotary,
   output logic              stepLeft,
   output logic              stepRight
);
   import rotaryPkg::*;

   quadPair stable;
   quadPair stableLast;

   logic [1:0] posNow;
   logic [1:0] posLast;
   logic [1:0] posDelta;

   logic moveRight;
   logic moveLeft;

   // position of a pair along the sequence 00, 01, 11, 10
   function automatic logic [1:0] grayPos(input quadPair pair);
      return {pair[1], pair[1] ^ pair[0]};
   endfunction

   rotaryFilter filterUnit (
      .clock  (clock),
      .reset  (reset),
      .rotary (rotary),
      .stable (stable)
   );

   assign posNow   = grayPos(stable);
   assign posLast  = grayPos(stableLast);
   assign posDelta = posNow - posLast;   // wraps modulo 4

   // delta of 2 means both lines flipped, no direction can be told
   assign moveRight = (posDelta == 2'd1);
   assign moveLeft  = (posDelta == 2'd3);

   always_ff @(posedge clock) begin
      if (reset) begin
         stableLast <= '0;               // filter also starts at 00
         stepLeft   <= 1'b0;
         stepRight  <= 1'b0;
      end else begin
         stableLast <= stable;
         stepLeft   <= moveLeft;         // single cycle, stableLast catches up
         stepRight  <= moveRight;
      end
   end

endmodule

//--- rotaryFilter.sv
`include "rotary_consts.svh"

module rotaryFilter #(
   parameter int stableCycles = `ROTARY_FILTER_CYCLES
) (
   input  logic              clock,
   input  logic              reset,
   input  rotaryPkg::quadPair rotary,
   output rotaryPkg::quadPair stable
);
   import rotaryPkg::*;

   quadPair    syncFirst;    // metastability stage
   quadPair    syncSecond;   // usable synchronized pair
   filterCount holdCount;

   logic pairMoved;
   logic pairIdle;
   logic holdDone;

   assign pairMoved = (syncFirst != syncSecond);   // pair changes on this edge
   assign pairIdle  = (syncSecond == stable);
   assign holdDone  = (holdCount == stableCycles);

   // raw lines are asynchronous to clock
   always_ff @(posedge clock) begin
      if (reset) begin
         syncFirst  <= '0;
         syncSecond <= '0;
      end else begin
         syncFirst  <= rotary;
         syncSecond <= syncFirst;
      end
   end

   // a candidate value is accepted only once it has stopped moving
   always_ff @(posedge clock) begin
      if (reset) begin
         holdCount <= '0;
         stable    <= '0;
      end else begin
         if (pairIdle || pairMoved) begin
            holdCount <= '0;            // bounce or nothing new
         end else if (holdDone) begin
            stable    <= syncSecond;
            holdCount <= '0;
         end else begin
            holdCount <= holdCount + 1'b1;
         end
      end
   end

endmodule

//--- rotaryPkg.sv
`include "rotary_consts.svh"

package rotaryPkg;

   // one instruction word and its opcode field
   typedef logic [`ROTARY_INST_WIDTH-1:0] instWord;
   typedef logic [`ROTARY_CODE_WIDTH-1:0] instCode;

   // encoder lines, bit 0 is phase A, bit 1 is phase B
   typedef logic [1:0] quadPair;

   // debounce counter, counts 0 .. ROTARY_FILTER_CYCLES
   typedef logic [$clog2(`ROTARY_FILTER_CYCLES + 1)-1:0] filterCount;

   typedef enum logic [1:0] {
      stateReset,
      stateReady,
      stateError
   } rotaryState;

endpackage

//--- rotary_consts.svh
`ifndef ROTARY_CONSTS_SVH
`define ROTARY_CONSTS_SVH

// instruction bus, opcode sits in the top bits
`define ROTARY_INST_WIDTH 12
`define ROTARY_CODE_WIDTH 4

// opcodes
`define ROTARY_OP_NOP 4'h0
`define ROTARY_OP_RDL 4'h1
`define ROTARY_OP_RDR 4'h2

// cycles a synchronized pair must hold still before it counts as a real change
`define ROTARY_FILTER_CYCLES 4

`endif
